/* common/kernel_pkg.sv */
package kernel_pkg;

	// window edge length
	localparam int K_SIZE = 3;

	typedef logic signed [3:0] coef_t;

	// sharpen kernel, row-major with the top row first
	// centre boosts the pixel, edge neighbours subtract, corners unused
	localparam coef_t KERNEL [K_SIZE*K_SIZE] = '{
		 0, -1,  0,
		-1,  5, -1,
		 0, -1,  0
	};

	// signed sum, range is -4*255 .. 5*255
	typedef logic signed [11:0] acc_t;

	// window register, products, sum
	localparam int CONV_STAGES = 3;

	// convolution plus the clamp register
	// delay in accepted slots from the line buffer taps to the output
	localparam int PIPE_SLOTS = CONV_STAGES + 1;

endpackage

/* common/pixel_pkg.sv */
package pixel_pkg;

	// width of one color sample
	localparam int CHAN_W = 8;

	// red, green and blue
	localparam int N_CHAN = 3;

	typedef logic [CHAN_W-1:0] chan_t;

	// red sits in the top byte, blue in the bottom byte
	typedef struct packed {
		chan_t red;
		chan_t green;
		chan_t blue;
	} pixel_t;

	// active image size, kept small for short runs
	localparam int IMG_W = 8;
	localparam int IMG_H = 6;

	// zero border around the image, (kernel size - 1) / 2 for a 3x3 kernel
	localparam int PAD = 1;
	localparam int PAD_W = IMG_W + 2 * PAD;
	localparam int PAD_H = IMG_H + 2 * PAD;

	// wide enough for padded rows and columns
	localparam int POS_W = 4;

	// clamp ceiling for a result sample
	localparam int CHAN_MAX = 255;

endpackage

/* conv/channel_conv.sv */
module channel_conv import pixel_pkg::*, kernel_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  i_adv,
	input  chan_t i_row0,
	input  chan_t i_row1,
	input  chan_t i_row2,
	output acc_t  o_sum
);

	localparam int TAPS = K_SIZE * K_SIZE;

	// win[r][c], r = 0 is the top row, c = K_SIZE-1 is the newest column
	chan_t win [K_SIZE][K_SIZE];
	chan_t row_in [K_SIZE];
	acc_t prod [TAPS];
	acc_t sum_next;

	// top row comes from the oldest tap
	assign row_in[0] = i_row0;
	assign row_in[1] = i_row1;
	assign row_in[2] = i_row2;

	// stage 1, shift new column in from the right
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int r = 0; r < K_SIZE; r++) begin
				for (int c = 0; c < K_SIZE; c++) begin
					win[r][c] <= '0;
				end
			end
		end else if (i_adv) begin
			for (int r = 0; r < K_SIZE; r++) begin
				win[r][K_SIZE-1] <= row_in[r];
				for (int c = 0; c < K_SIZE - 1; c++) begin
					win[r][c] <= win[r][c+1];
				end
			end
		end
	end

	// stage 2, samples are unsigned so a zero bit goes on top before the multiply
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < TAPS; i++) begin
				prod[i] <= '0;
			end
		end else if (i_adv) begin
			for (int i = 0; i < TAPS; i++) begin
				prod[i] <= $signed({1'b0, win[i / K_SIZE][i % K_SIZE]}) * KERNEL[i];
			end
		end
	end

	// adder tree, partial sums stay inside acc_t
	always_comb begin
		sum_next = '0;
		for (int i = 0; i < TAPS; i++) begin
			sum_next = sum_next + prod[i];
		end
	end

	// stage 3
	always_ff @(posedge clk) begin
		if (reset) begin
			o_sum <= '0;
		end else if (i_adv) begin
			o_sum <= sum_next;
		end
	end

endmodule

/* conv/conv_post.sv */
module conv_post import pixel_pkg::*, kernel_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  logic   i_adv,
	input  pixel_t i_tap0,
	input  pixel_t i_tap1,
	input  pixel_t i_tap2,
	input  logic   i_win_valid,
	input  logic   i_frame_end,
	output pixel_t o_pixel,
	output logic   o_valid,
	output logic   o_done
);

	// index 0 is blue, N_CHAN-1 is red
	acc_t sum [N_CHAN];

	// clamped result
	pixel_t res;

	// flag delay lines, bit 0 is the newest
	logic [PIPE_SLOTS-1:0] valid_pipe;
	logic [PIPE_SLOTS-1:0] done_pipe;

	// saturate a signed sum into one sample
	function automatic chan_t clamp(input acc_t v);
		if (v > CHAN_MAX) begin
			return chan_t'(CHAN_MAX);
		end else if (v < 0) begin
			return '0;
		end else begin
			return v[CHAN_W-1:0];
		end
	endfunction

	// one convolver per color channel, top row from the oldest tap
	for (genvar ch = 0; ch < N_CHAN; ch++) begin : g_chan
		channel_conv u_conv (
			.clk(clk),
			.reset(reset),
			.i_adv(i_adv),
			.i_row0(i_tap2[CHAN_W*ch +: CHAN_W]),
			.i_row1(i_tap1[CHAN_W*ch +: CHAN_W]),
			.i_row2(i_tap0[CHAN_W*ch +: CHAN_W]),
			.o_sum(sum[ch])
		);
	end

	// clamp stage plus flags, all held while no pixel is accepted
	always_ff @(posedge clk) begin
		if (reset) begin
			res <= '0;
			valid_pipe <= '0;
			done_pipe <= '0;
		end else if (i_adv) begin
			for (int ch = 0; ch < N_CHAN; ch++) begin
				res[CHAN_W*ch +: CHAN_W] <= clamp(sum[ch]);
			end
			valid_pipe <= {valid_pipe[PIPE_SLOTS-2:0], i_win_valid};
			done_pipe <= {done_pipe[PIPE_SLOTS-2:0], i_frame_end};
		end
	end

	assign o_pixel = res;

	// flags only show in a slot that holds an accepted pixel
	assign o_valid = i_adv & valid_pipe[PIPE_SLOTS-1];
	assign o_done = i_adv & done_pipe[PIPE_SLOTS-1];

	// a reset cycle leaves the output quiet on the next edge
	a_quiet_in_reset: assert property (
		@(posedge clk)
		reset |=> !(o_valid || o_done)
	);

endmodule

/* dv/sharpen_filter_tb.sv */
module sharpen_filter_tb import pixel_pkg::*, kernel_pkg::*;;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DLY = 5;
	localparam int N_FRAMES = 3;
	localparam int FRAME_LEN = PAD_W * PAD_H;
	// padded frames plus flush pixels that push the last results out
	localparam int STREAM_LEN = N_FRAMES * FRAME_LEN + PIPE_SLOTS;
	localparam int OUT_PER_FRAME = IMG_W * IMG_H;
	// four cycles per stimulus pixel, reset and some slack
	localparam int WATCHDOG_CYCLES = STREAM_LEN * 4 + 4 + 100;

	logic clk;
	logic reset;
	logic i_valid;
	pixel_t i_pixel;
	pixel_t o_pixel;
	logic o_valid;
	logic o_done;

	integer seed = 32'h3a3b5d6f;

	// padded source frames, zero border
	pixel_t frame_mem [N_FRAMES][PAD_H][PAD_W];

	// model results in output order
	pixel_t exp_q [$];

	int accepted = 0;
	int frame_valid = 0;
	int total_valid = 0;
	int done_count = 0;
	int clamp_lo = 0;
	int clamp_hi = 0;

	sharpen_filter dut (
		.clk(clk),
		.reset(reset),
		.i_valid(i_valid),
		.i_pixel(i_pixel),
		.o_pixel(o_pixel),
		.o_valid(o_valid),
		.o_done(o_done)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1, "run stopped at first error");
	endtask

	// saturate a model sum to one sample, and note which limit was hit
	function automatic chan_t clamp_sample(input int v);
		if (v > CHAN_MAX) begin
			clamp_hi++;
			return chan_t'(CHAN_MAX);
		end else if (v < 0) begin
			clamp_lo++;
			return '0;
		end else begin
			return chan_t'(v);
		end
	endfunction

	// window with bottom-right corner at padded (r, c), centre at (r-1, c-1)
	function automatic pixel_t expected_pixel(input int f, input int r, input int c);
		pixel_t q;
		pixel_t res;
		int kv;
		int acc_r;
		int acc_g;
		int acc_b;
		int s;
		acc_r = 0;
		acc_g = 0;
		acc_b = 0;
		for (int i = 0; i < K_SIZE; i++) begin
			for (int j = 0; j < K_SIZE; j++) begin
				q = frame_mem[f][r-2+i][c-2+j];
				kv = KERNEL[i*K_SIZE+j];
				s = q.red;
				acc_r += kv * s;
				s = q.green;
				acc_g += kv * s;
				s = q.blue;
				acc_b += kv * s;
			end
		end
		res.red = clamp_sample(acc_r);
		res.green = clamp_sample(acc_g);
		res.blue = clamp_sample(acc_b);
		return res;
	endfunction

	// random interior, zero border
	task automatic build_frames;
		logic [31:0] rnd;
		for (int f = 0; f < N_FRAMES; f++) begin
			for (int r = 0; r < PAD_H; r++) begin
				for (int c = 0; c < PAD_W; c++) begin
					rnd = $random(seed);
					if (r < PAD || r >= PAD_H - PAD || c < PAD || c >= PAD_W - PAD) begin
						frame_mem[f][r][c] = '0;
					end else begin
						frame_mem[f][r][c] = rnd[23:0];
					end
				end
			end
		end
	endtask

	// stream frames back to back with random idle cycles
	task automatic drive_stream;
		pixel_t p;
		int f;
		int pos;
		int r;
		int c;
		for (int k = 0; k < STREAM_LEN; k++) begin
			// roughly one idle cycle in four
			while (($random(seed) & 3) == 0) begin
				i_valid = 1'b0;
				@(posedge clk);
				#DRIVE_DLY;
			end
			if (k < N_FRAMES * FRAME_LEN) begin
				f = k / FRAME_LEN;
				pos = k % FRAME_LEN;
				r = pos / PAD_W;
				c = pos % PAD_W;
				p = frame_mem[f][r][c];
				// full window available only from the third row and column
				if (r >= 2 * PAD && c >= 2 * PAD) begin
					exp_q.push_back(expected_pixel(f, r, c));
				end
			end else begin
				p = '0;
			end
			i_valid = 1'b1;
			i_pixel = p;
			@(posedge clk);
			#DRIVE_DLY;
		end
		i_valid = 1'b0;
		i_pixel = '0;
	endtask

	// pixels taken into the input register
	always @(posedge clk) begin
		if (!reset && i_valid) begin
			accepted <= accepted + 1;
		end
	end

	// outputs settle after the rising edge, so look at them on the falling one
	always @(negedge clk) begin
		pixel_t exp_pix;
		if (reset) begin
			assert (o_valid === 1'b0 && o_done === 1'b0 && o_pixel === '0) else
				fail_run($sformatf("** Error at %0d ns: output not cleared during reset",
					$time));
		end else begin
			assert (!$isunknown({o_valid, o_done})) else
				fail_run($sformatf("** Error at %0d ns: output flag unknown", $time));
			if (o_valid || o_done) begin
				// nothing can come out before a pixel crossed the pipeline
				assert (accepted > PIPE_SLOTS) else
					fail_run($sformatf("** Error at %0d ns: flag after only %0d pixels",
						$time, accepted));
			end
			if (o_valid) begin
				assert (exp_q.size() > 0) else
					fail_run($sformatf("** Error at %0d ns: unexpected valid output", $time));
				exp_pix = exp_q.pop_front();
				assert (o_pixel === exp_pix) else
					fail_run($sformatf("** Error at %0d ns: pixel %0d got %h expected %h",
						$time, total_valid, o_pixel, exp_pix));
				frame_valid++;
				total_valid++;
				assert (frame_valid <= OUT_PER_FRAME) else
					fail_run($sformatf("** Error at %0d ns: too many outputs in frame %0d",
						$time, done_count));
			end
			// done may share the cycle with the last valid output of its frame
			if (o_done) begin
				assert (frame_valid == OUT_PER_FRAME) else
					fail_run($sformatf("** Error at %0d ns: done after %0d outputs",
						$time, frame_valid));
				done_count++;
				frame_valid = 0;
				assert (done_count <= N_FRAMES) else
					fail_run($sformatf("** Error at %0d ns: extra done pulse", $time));
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		fail_run("Timeout: the output never completed all frames");
	end

	initial begin
		reset = 1'b1;
		i_valid = 1'b0;
		i_pixel = '0;
		build_frames();
		repeat (4) @(posedge clk);
		#DRIVE_DLY;
		reset = 1'b0;
		drive_stream();
		// last done comes out with the flush pixels
		while (done_count < N_FRAMES) begin
			@(posedge clk);
		end
		repeat (PIPE_SLOTS + 2) @(posedge clk);
		assert (exp_q.size() == 0) else
			fail_run($sformatf("** Error at %0d ns: %0d expected pixels never came out",
				$time, exp_q.size()));
		assert (clamp_lo > 0 && clamp_hi > 0) else
			fail_run("The random frames never reached both clamp limits");
		$display("Regression passed");
		$finish;
	end

endmodule

/* hdl/frame_tracker.sv */
module frame_tracker import pixel_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  logic   i_valid,
	input  pixel_t i_pixel,
	output logic   o_adv,
	output pixel_t o_pixel,
	output logic   o_win_valid,
	output logic   o_frame_end
);

	// registered strobe and pixel
	logic adv;
	pixel_t in_pixel;

	// position of the pixel held in the input register
	logic [POS_W-1:0] col;
	logic [POS_W-1:0] row;

	// full padded rows seen so far in this frame, saturates at 2*PAD
	logic [POS_W-1:0] ready_rows;

	// input register
	// adv is the registered strobe and steps every stage downstream
	always_ff @(posedge clk) begin
		if (reset) begin
			adv <= 1'b0;
			in_pixel <= '0;
		end else begin
			adv <= i_valid;
			in_pixel <= i_pixel;
		end
	end

	// counters move only when the held pixel is an accepted one
	always_ff @(posedge clk) begin
		if (reset) begin
			col <= '0;
			row <= '0;
			ready_rows <= '0;
		end else if (adv) begin
			if (col == PAD_W - 1) begin
				col <= '0;
				if (row == PAD_H - 1) begin
					// frame complete, start over for a back to back frame
					row <= '0;
					ready_rows <= '0;
				end else begin
					row <= row + 1'b1;
					if (ready_rows < 2 * PAD) begin
						ready_rows <= ready_rows + 1'b1;
					end
				end
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	assign o_adv = adv;
	assign o_pixel = in_pixel;

	// the window ending at this pixel lies fully inside the padded frame
	// once two rows above are buffered and two columns to the left exist
	assign o_win_valid = (ready_rows == 2 * PAD) && (col >= 2 * PAD);

	// last padded pixel of the frame
	assign o_frame_end = (row == PAD_H - 1) && (col == PAD_W - 1);

	// column wraps before it can leave the padded width
	a_col_range: assert property (
		@(posedge clk) disable iff (reset)
		col < PAD_W
	);

endmodule

/* hdl/sharpen_filter.sv */
module sharpen_filter import pixel_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  logic   i_valid,
	input  pixel_t i_pixel,
	output pixel_t o_pixel,
	output logic   o_valid,
	output logic   o_done
);

	// advance enable for everything past the input register
	logic adv;
	pixel_t in_pixel;

	// window and end-of-frame flags, aligned with tap0
	logic win_valid;
	logic frame_end;

	// bottom, middle and top rows of the window
	pixel_t tap0;
	pixel_t tap1;
	pixel_t tap2;

	frame_tracker u_tracker (
		.clk(clk),
		.reset(reset),
		.i_valid(i_valid),
		.i_pixel(i_pixel),
		.o_adv(adv),
		.o_pixel(in_pixel),
		.o_win_valid(win_valid),
		.o_frame_end(frame_end)
	);

	line_buffer u_lines (
		.clk(clk),
		.reset(reset),
		.i_adv(adv),
		.i_pixel(in_pixel),
		.o_tap0(tap0),
		.o_tap1(tap1),
		.o_tap2(tap2)
	);

	conv_post u_post (
		.clk(clk),
		.reset(reset),
		.i_adv(adv),
		.i_tap0(tap0),
		.i_tap1(tap1),
		.i_tap2(tap2),
		.i_win_valid(win_valid),
		.i_frame_end(frame_end),
		.o_pixel(o_pixel),
		.o_valid(o_valid),
		.o_done(o_done)
	);

endmodule

/* line_buffer/line_buffer.sv */
module line_buffer import pixel_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  logic   i_adv,
	input  pixel_t i_pixel,
	output pixel_t o_tap0,
	output pixel_t o_tap1,
	output pixel_t o_tap2
);

	// two padded rows of history
	localparam int DEPTH = 2 * PAD * PAD_W;

	pixel_t sr [DEPTH];

	// accepted pixels shifted in, stops at DEPTH
	logic [$clog2(DEPTH+1)-1:0] fill;

	// sr[0] holds the previous accepted pixel
	always_ff @(posedge clk) begin
		if (i_adv) begin
			sr[0] <= i_pixel;
			for (int i = 1; i < DEPTH; i++) begin
				sr[i] <= sr[i-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			fill <= '0;
		end else if (i_adv && (fill != DEPTH)) begin
			fill <= fill + 1'b1;
		end
	end

	// bottom row is the pixel in the input register itself
	assign o_tap0 = i_pixel;
	// one padded row up
	assign o_tap1 = sr[PAD_W-1];
	// two padded rows up
	assign o_tap2 = sr[DEPTH-1];

	// every tap carries a real pixel once the buffer has been filled
	a_taps_known: assert property (
		@(posedge clk) disable iff (reset)
		((fill == DEPTH) && i_adv) |-> !$isunknown({o_tap0, o_tap1, o_tap2})
	);

endmodule

/* sharpen_filter.f */
common/pixel_pkg.sv
common/kernel_pkg.sv
hdl/frame_tracker.sv
line_buffer/line_buffer.sv
conv/channel_conv.sv
conv/conv_post.sv
hdl/sharpen_filter.sv
dv/sharpen_filter_tb.sv
